//--- dv/bus_ctrl_properties.sv
`timescale 1ns/1ps

module bus_ctrl_properties (
   input logic                      clk,
   input logic                      i_arst_n,
   input logic                      i_rb_rd_stb,
   input logic                      i_rb_valid,
   input logic                      i_set_stb,
   input bus_ctrl_pkg::set_addr_t   i_set_addr,
   input logic                      i_ref_freq_changed,
   input logic                      i_sfp0_clear,
   input logic                      i_sfp1_clear,
   input bus_ctrl_pkg::sfp_status_t i_sfp0_status,
   input bus_ctrl_pkg::sfp_status_t i_sfp1_status
);

   logic [2:0] sfp0_flags;
   logic [2:0] sfp1_flags;

   assign sfp0_flags = {i_sfp0_status.mod_abs_chgd, i_sfp0_status.tx_fault_chgd,
                        i_sfp0_status.rx_los_chgd};
   assign sfp1_flags = {i_sfp1_status.mod_abs_chgd, i_sfp1_status.tx_fault_chgd,
                        i_sfp1_status.rx_los_chgd};

   // --------------------------------------------------
   // Readback handshake
   // --------------------------------------------------
   rb_valid_after_stb: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_rb_rd_stb |=> i_rb_valid)
      else $error("o_rb_valid missing one cycle after a read strobe");

   rb_valid_only_after_stb: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_rb_valid |-> $past(i_rb_rd_stb))
      else $error("o_rb_valid high without a read strobe in the previous cycle");

   // Strobe only for the reference frequency address
   ref_freq_strobe: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_ref_freq_changed |-> $past(i_set_stb && (i_set_addr == bus_ctrl_pkg::SR_REF_FREQ)))
      else $error("o_ref_freq_changed without a write to SR_REF_FREQ");

   // Clear on read beats a change on the same edge
   sfp0_clear_wins: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_sfp0_clear |=> (sfp0_flags == 3'b000))
      else $error("SFP+ port 0 change flag set in the cycle after its clear");

   sfp1_clear_wins: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_sfp1_clear |=> (sfp1_flags == 3'b000))
      else $error("SFP+ port 1 change flag set in the cycle after its clear");

endmodule

bind bus_ctrl_top bus_ctrl_properties props (
   .clk(clk), .i_arst_n(i_arst_n), .i_rb_rd_stb(i_rb_rd_stb), .i_rb_valid(o_rb_valid),
   .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_ref_freq_changed(o_ref_freq_changed),
   .i_sfp0_clear(sfp0_clear), .i_sfp1_clear(sfp1_clear),
   .i_sfp0_status(sfp0_status), .i_sfp1_status(sfp1_status)
);

//--- dv/bus_ctrl_tb.sv
`timescale 1ns/1ps

module bus_ctrl_tb;

   typedef enum int {K_CHECK, K_WRITE, K_READ, K_COUNT, K_PIN} kind_t;

   localparam int MAX_TESTS = 40;
   localparam bus_ctrl_pkg::set_addr_t OUT_ADDRS [7] = '{8'd0, 8'd1, 8'd2, 8'd4, 8'd8, 8'd9, 8'd72};

   logic                                     clk;
   logic                                     i_arst_n;
   logic                                     i_set_stb;
   bus_ctrl_pkg::set_addr_t                  i_set_addr;
   bus_ctrl_pkg::set_data_t                  i_set_data;
   logic                                     i_rb_rd_stb;
   bus_ctrl_pkg::rb_addr_t                   i_rb_addr;
   bus_ctrl_pkg::rb_data_t                   o_rb_data;
   logic                                     o_rb_valid;
   logic [7:0]                               i_clock_status;
   bus_ctrl_pkg::phy_status_t                i_sfp0_phy_status;
   bus_ctrl_pkg::phy_status_t                i_sfp1_phy_status;
   logic [2:0]                               pins0;
   logic [2:0]                               pins1;
   logic [bus_ctrl_pkg::LEDS_W-1:0]          o_leds;
   logic [bus_ctrl_pkg::SW_RST_W-1:0]        o_sw_rst;
   logic [bus_ctrl_pkg::CLOCK_CTRL_W-1:0]    o_clock_control;
   bus_ctrl_pkg::set_data_t                  o_ref_freq;
   logic                                     o_ref_freq_changed;
   logic [bus_ctrl_pkg::GPIO_SRC_W-1:0]      o_fp_gpio_src;
   logic [bus_ctrl_pkg::SFPP_CTRL_W-1:0]     o_sfpp0_rs;
   logic [bus_ctrl_pkg::SFPP_CTRL_W-1:0]     o_sfpp1_rs;

   // Test table with one column per array
   string                    tname [MAX_TESTS];
   kind_t                    tkind [MAX_TESTS];
   bus_ctrl_pkg::set_addr_t  taddr [MAX_TESTS];
   bus_ctrl_pkg::set_data_t  tdata [MAX_TESTS];
   bus_ctrl_pkg::set_data_t  texp  [MAX_TESTS];
   bus_ctrl_pkg::set_data_t  shadow [256];
   logic [2:0]               m_pins [2];
   logic [2:0]               m_flags [2];
   int                       n_tests = 0;
   int                       n_pass = 0;
   int                       errors = 0;
   int                       cycles;

   // Pins ordered {mod_abs, tx_fault, rx_los}
   bus_ctrl_top DUT (
      .*,
      .i_sfpp0_mod_abs(pins0[2]), .i_sfpp0_tx_fault(pins0[1]), .i_sfpp0_rx_los(pins0[0]),
      .i_sfpp1_mod_abs(pins1[2]), .i_sfpp1_tx_fault(pins1[1]), .i_sfpp1_rx_los(pins1[0])
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // --------------------------------------------------
   // Reference model helpers
   // --------------------------------------------------
   function automatic bus_ctrl_pkg::set_data_t fit(input bus_ctrl_pkg::set_addr_t addr,
                                                   input bus_ctrl_pkg::set_data_t d);
      int w;
      case (addr)
         bus_ctrl_pkg::SR_LEDS:        w = bus_ctrl_pkg::LEDS_W;
         bus_ctrl_pkg::SR_SW_RST:      w = bus_ctrl_pkg::SW_RST_W;
         bus_ctrl_pkg::SR_CLOCK_CTRL:  w = bus_ctrl_pkg::CLOCK_CTRL_W;
         bus_ctrl_pkg::SR_DEVICE_ID:   w = bus_ctrl_pkg::DEVICE_ID_W;
         bus_ctrl_pkg::SR_REF_FREQ:    w = 32;
         bus_ctrl_pkg::SR_SFPP_CTRL0:  w = bus_ctrl_pkg::SFPP_CTRL_W;
         bus_ctrl_pkg::SR_SFPP_CTRL1:  w = bus_ctrl_pkg::SFPP_CTRL_W;
         bus_ctrl_pkg::SR_FP_GPIO_SRC: w = bus_ctrl_pkg::GPIO_SRC_W;
         default:                      w = 0;
      endcase
      return (w >= 32) ? d : (d & ((32'd1 << w) - 32'd1));
   endfunction

   function automatic bus_ctrl_pkg::set_data_t reg_out(input bus_ctrl_pkg::set_addr_t addr);
      case (addr)
         bus_ctrl_pkg::SR_LEDS:        return 32'(o_leds);
         bus_ctrl_pkg::SR_SW_RST:      return 32'(o_sw_rst);
         bus_ctrl_pkg::SR_CLOCK_CTRL:  return 32'(o_clock_control);
         bus_ctrl_pkg::SR_REF_FREQ:    return o_ref_freq;
         bus_ctrl_pkg::SR_SFPP_CTRL0:  return 32'(o_sfpp0_rs);
         bus_ctrl_pkg::SR_SFPP_CTRL1:  return 32'(o_sfpp1_rs);
         default:                      return 32'(o_fp_gpio_src);
      endcase
   endfunction

   task automatic add_entry(input string name, input kind_t kind,
                            input bus_ctrl_pkg::set_addr_t addr,
                            input bus_ctrl_pkg::set_data_t data,
                            input bus_ctrl_pkg::set_data_t exp);
      tname[n_tests] = name;
      tkind[n_tests] = kind;
      taddr[n_tests] = addr;
      tdata[n_tests] = data;
      texp[n_tests]  = exp;
      n_tests++;
   endtask

   // Expected status word before the read clears the model flags
   task automatic add_status_read(input string name, input int port);
      bus_ctrl_pkg::sfp_status_t s;
      s               = '0;
      s.phy_status    = (port == 0) ? i_sfp0_phy_status : i_sfp1_phy_status;
      s.mod_abs_chgd  = m_flags[port][2];
      s.tx_fault_chgd = m_flags[port][1];
      s.rx_los_chgd   = m_flags[port][0];
      {s.mod_abs, s.tx_fault, s.rx_los} = m_pins[port];
      add_entry(name, K_READ, (port == 0) ? 8'd8 : 8'd9, '0, s);
      m_flags[port] = 3'b000;
   endtask

   task automatic add_pin_toggle(input string name, input int port, input logic [2:0] mask);
      add_entry(name, K_PIN, 8'(port), 32'(mask), '0);
      m_pins[port]  = m_pins[port] ^ mask;
      m_flags[port] = m_flags[port] | mask;
   endtask

   task automatic build_table();
      bus_ctrl_pkg::set_data_t d;
      bus_ctrl_pkg::set_data_t dev_id_m;
      bus_ctrl_pkg::set_data_t gpio_m;
      bus_ctrl_pkg::set_addr_t wr_addrs [11];
      wr_addrs = '{8'd0, 8'd1, 8'd2, 8'd3, 8'd4, 8'd4, 8'd8, 8'd9, 8'd72, 8'd5, 8'd100};
      m_pins[0] = pins0;
      m_pins[1] = pins1;
      m_flags[0] = 3'b000;
      m_flags[1] = 3'b000;
      add_entry("reset leds", K_CHECK, 8'd0, '0, '0);
      add_entry("reset sw_rst", K_CHECK, 8'd1, '0, '0);
      add_entry("reset clock_ctrl", K_CHECK, 8'd2, '0, 32'h40);
      add_entry("reset ref_freq", K_CHECK, 8'd4, '0, 32'd10_000_000);
      add_entry("reset sfpp0_rs", K_CHECK, 8'd8, '0, '0);
      add_entry("reset sfpp1_rs", K_CHECK, 8'd9, '0, '0);
      add_entry("reset gpio_src", K_CHECK, 8'd72, '0, '0);
      add_entry("compat number", K_READ, 8'd6, '0, 32'h0026_0000);
      foreach (wr_addrs[j]) begin
         d = $urandom();
         add_entry($sformatf("write addr %0d", wr_addrs[j]), K_WRITE, wr_addrs[j], d,
                   fit(wr_addrs[j], d));
         if (wr_addrs[j] == 8'd3) dev_id_m = fit(wr_addrs[j], d);
         if (wr_addrs[j] == 8'd72) gpio_m = fit(wr_addrs[j], d);
      end
      add_entry("rfnoc info", K_READ, 8'd7, '0, {dev_id_m[15:0], 16'h0100});
      add_entry("gpio src readback", K_READ, 8'd13, '0, gpio_m);
      add_entry("clock status", K_READ, 8'd3, '0, 32'(i_clock_status));
      add_entry("unmapped read", K_READ, 8'd20, '0, '0);
      add_entry("counter gap 5", K_COUNT, 8'd0, 32'd5, 32'd5);
      add_entry("counter gap 9", K_COUNT, 8'd0, 32'd9, 32'd9);
      // Each port is read while the other one holds a pending flag
      add_status_read("sfp0 idle", 0);
      add_pin_toggle("sfp0 toggle mod_abs", 0, 3'b100);
      add_status_read("sfp1 untouched", 1);
      add_status_read("sfp0 flag set", 0);
      add_status_read("sfp0 flag cleared", 0);
      add_pin_toggle("sfp1 toggle tx_fault rx_los", 1, 3'b011);
      add_status_read("sfp0 untouched", 0);
      add_status_read("sfp1 flags set", 1);
      add_status_read("sfp1 flags cleared", 1);
   endtask

   // --------------------------------------------------
   // Bus tasks and compares
   // --------------------------------------------------
   task automatic check_rb(input string name, input bus_ctrl_pkg::rb_data_t exp,
                           input bus_ctrl_pkg::rb_data_t act);
      if (act !== exp) begin
         $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_reg(input string name, input bus_ctrl_pkg::set_data_t exp,
                            input bus_ctrl_pkg::set_data_t act);
      if (act !== exp) begin
         $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act);
         errors++;
      end
   endtask

   task automatic write_setting(input bus_ctrl_pkg::set_addr_t addr,
                                input bus_ctrl_pkg::set_data_t data);
      @(posedge clk);
      i_set_stb  <= 1'b1;
      i_set_addr <= addr;
      i_set_data <= data;
      @(posedge clk);
      i_set_stb  <= 1'b0;
   endtask

   task automatic rb_read(input bus_ctrl_pkg::rb_addr_t addr,
                          output bus_ctrl_pkg::rb_data_t data, output bit ok);
      int waited;
      @(posedge clk);
      i_rb_rd_stb <= 1'b1;
      i_rb_addr   <= addr;
      @(posedge clk);
      i_rb_rd_stb <= 1'b0;
      ok = 1'b0;
      waited = 0;
      while (!ok && waited < 4) begin
         @(negedge clk);
         ok = o_rb_valid;
         waited++;
      end
      data = o_rb_data;
      if (!ok) begin
         $display("Read of address %0d never raised o_rb_valid", addr);
         errors++;
      end
   endtask

   initial begin : watchdog
      cycles = 0;
      wait (n_tests > 0);
      while (cycles < n_tests * 12 + 50) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("Regression failed");
      $finish;
   end

   initial begin : main
      bus_ctrl_pkg::rb_data_t first;
      bus_ctrl_pkg::rb_data_t second;
      bit ok;
      int errs_before;
      void'($urandom(85));
      i_arst_n          = 1'b0;
      i_set_stb         = 1'b0;
      i_set_addr        = '0;
      i_set_data        = '0;
      i_rb_rd_stb       = 1'b0;
      i_rb_addr         = '0;
      i_clock_status    = 8'($urandom());
      i_sfp0_phy_status = 16'($urandom());
      i_sfp1_phy_status = 16'($urandom());
      pins0             = 3'b100;
      pins1             = 3'b001;
      build_table();
      repeat (5) @(posedge clk);
      i_arst_n <= 1'b1;
      for (int i = 0; i < n_tests; i++) begin
         errs_before = errors;
         case (tkind[i])
            K_CHECK: begin
               @(negedge clk);
               shadow[taddr[i]] = texp[i];
               check_reg(tname[i], texp[i], reg_out(taddr[i]));
            end
            K_WRITE: begin
               shadow[taddr[i]] = texp[i];
               write_setting(taddr[i], tdata[i]);
               @(negedge clk);
               foreach (OUT_ADDRS[j]) begin
                  check_reg(tname[i], shadow[OUT_ADDRS[j]], reg_out(OUT_ADDRS[j]));
               end
               check_reg({tname[i], " strobe"}, 32'(taddr[i] == 8'd4), 32'(o_ref_freq_changed));
               @(negedge clk);
               check_reg({tname[i], " strobe end"}, '0, 32'(o_ref_freq_changed));
            end
            K_READ: begin
               rb_read(taddr[i], first, ok);
               if (ok) check_rb(tname[i], texp[i], first);
            end
            K_COUNT: begin
               // Second strobe lands exactly tdata cycles after the first
               rb_read(taddr[i], first, ok);
               repeat (tdata[i] - 2) @(posedge clk);
               rb_read(taddr[i], second, ok);
               check_rb(tname[i], texp[i], second - first);
            end
            default: begin
               @(posedge clk);
               if (taddr[i] == 0) pins0 <= pins0 ^ tdata[i][2:0];
               else pins1 <= pins1 ^ tdata[i][2:0];
               repeat (6) @(posedge clk);
            end
         endcase
         if (errors == errs_before) begin
            n_pass++;
            $display("[PASS] %s", tname[i]);
         end else begin
            $display("[ERROR] %s finished with %0d failed check(s)", tname[i], errors - errs_before);
         end
      end
      $display("Tests run %0d, passed %0d, failed %0d, failed checks %0d",
               n_tests, n_pass, n_tests - n_pass, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- sim.f
src/bus_ctrl_pkg.sv
src/setting_reg.sv
src/sfp_status_monitor.sv
src/readback_mux.sv
src/bus_ctrl_top.sv
dv/bus_ctrl_properties.sv
dv/bus_ctrl_tb.sv

//--- src/bus_ctrl_pkg.sv
package bus_ctrl_pkg;

   // --------------------------------------------------
   // Bus types
   // --------------------------------------------------
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [7:0]  rb_addr_t;
   typedef logic [31:0] rb_data_t;
   typedef logic [15:0] phy_status_t;

   // SFP+ status readback word, MSB first
   typedef struct packed {
      phy_status_t phy_status;
      logic [9:0]  zero_pad;
      logic        mod_abs_chgd;
      logic        tx_fault_chgd;
      logic        rx_los_chgd;
      logic        mod_abs;
      logic        tx_fault;
      logic        rx_los;
   } sfp_status_t;

   // --------------------------------------------------
   // Settings bus address map
   // --------------------------------------------------
   localparam set_addr_t SR_LEDS        = 8'd0;
   localparam set_addr_t SR_SW_RST      = 8'd1;
   localparam set_addr_t SR_CLOCK_CTRL  = 8'd2;
   localparam set_addr_t SR_DEVICE_ID   = 8'd3;
   localparam set_addr_t SR_REF_FREQ    = 8'd4;
   localparam set_addr_t SR_SFPP_CTRL0  = 8'd8;
   localparam set_addr_t SR_SFPP_CTRL1  = 8'd9;
   localparam set_addr_t SR_FP_GPIO_SRC = 8'd72;

   // --------------------------------------------------
   // Readback bus address map
   // --------------------------------------------------
   localparam rb_addr_t RB_COUNTER      = 8'd0;
   localparam rb_addr_t RB_CLK_STATUS   = 8'd3;
   localparam rb_addr_t RB_COMPAT_NUM   = 8'd6;
   localparam rb_addr_t RB_RFNOC_INFO   = 8'd7;
   localparam rb_addr_t RB_SFPP_STATUS0 = 8'd8;
   localparam rb_addr_t RB_SFPP_STATUS1 = 8'd9;
   localparam rb_addr_t RB_FP_GPIO_SRC  = 8'd13;

   // Register widths
   localparam int LEDS_W       = 2;
   localparam int SW_RST_W     = 4;
   localparam int CLOCK_CTRL_W = 8;
   localparam int DEVICE_ID_W  = 16;
   localparam int GPIO_SRC_W   = 24;
   localparam int SFPP_CTRL_W  = 2;

   // Reset values and identification constants
   localparam logic [CLOCK_CTRL_W-1:0] CLOCK_CTRL_RESET = 8'h40;  // GPSDO on
   localparam set_data_t               REF_FREQ_RESET   = 32'd10_000_000;
   localparam logic [15:0]             COMPAT_MAJOR     = 16'h0026;
   localparam logic [15:0]             COMPAT_MINOR     = 16'h0000;
   localparam logic [15:0]             PROTOVER         = 16'h0100;

endpackage

//--- src/bus_ctrl_top.sv
`timescale 1ns/1ps

module bus_ctrl_top (
   input  logic                                      clk,
   input  logic                                      i_arst_n,
   // Settings bus
   input  logic                                      i_set_stb,
   input  bus_ctrl_pkg::set_addr_t                   i_set_addr,
   input  bus_ctrl_pkg::set_data_t                   i_set_data,
   // Readback bus
   input  logic                                      i_rb_rd_stb,
   input  bus_ctrl_pkg::rb_addr_t                    i_rb_addr,
   output bus_ctrl_pkg::rb_data_t                    o_rb_data,
   output logic                                      o_rb_valid,
   // Board status inputs
   input  logic [7:0]                                i_clock_status,
   input  logic                                      i_sfpp0_mod_abs,
   input  logic                                      i_sfpp0_tx_fault,
   input  logic                                      i_sfpp0_rx_los,
   input  logic                                      i_sfpp1_mod_abs,
   input  logic                                      i_sfpp1_tx_fault,
   input  logic                                      i_sfpp1_rx_los,
   input  bus_ctrl_pkg::phy_status_t                 i_sfp0_phy_status,
   input  bus_ctrl_pkg::phy_status_t                 i_sfp1_phy_status,
   // Control outputs
   output logic [bus_ctrl_pkg::LEDS_W-1:0]           o_leds,
   output logic [bus_ctrl_pkg::SW_RST_W-1:0]         o_sw_rst,
   output logic [bus_ctrl_pkg::CLOCK_CTRL_W-1:0]     o_clock_control,
   output bus_ctrl_pkg::set_data_t                   o_ref_freq,
   output logic                                      o_ref_freq_changed,
   output logic [bus_ctrl_pkg::GPIO_SRC_W-1:0]       o_fp_gpio_src,
   output logic [bus_ctrl_pkg::SFPP_CTRL_W-1:0]      o_sfpp0_rs,
   output logic [bus_ctrl_pkg::SFPP_CTRL_W-1:0]      o_sfpp1_rs
);

   logic [bus_ctrl_pkg::DEVICE_ID_W-1:0] device_id;
   bus_ctrl_pkg::sfp_status_t            sfp0_status;
   bus_ctrl_pkg::sfp_status_t            sfp1_status;
   logic                                 sfp0_clear;
   logic                                 sfp1_clear;

   // --------------------------------------------------
   // Settings registers
   // --------------------------------------------------
   setting_reg #(
      .T    (logic [bus_ctrl_pkg::LEDS_W-1:0]),
      .ADDR (bus_ctrl_pkg::SR_LEDS)
   ) set_leds (
      .clk(clk), .i_arst_n(i_arst_n),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .o_value(o_leds), .o_changed()
   );

   // Bit 0 PHY, bit 1 radio domain, bit 2 radio PLL, bit 3 ADC delay control
   setting_reg #(
      .T    (logic [bus_ctrl_pkg::SW_RST_W-1:0]),
      .ADDR (bus_ctrl_pkg::SR_SW_RST)
   ) set_sw_rst (
      .clk(clk), .i_arst_n(i_arst_n),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .o_value(o_sw_rst), .o_changed()
   );

   setting_reg #(
      .T         (logic [bus_ctrl_pkg::CLOCK_CTRL_W-1:0]),
      .ADDR      (bus_ctrl_pkg::SR_CLOCK_CTRL),
      .RESET_VAL (bus_ctrl_pkg::CLOCK_CTRL_RESET)
   ) set_clk_ctrl (
      .clk(clk), .i_arst_n(i_arst_n),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .o_value(o_clock_control), .o_changed()
   );

   // Device ID only goes to readback
   setting_reg #(
      .T    (logic [bus_ctrl_pkg::DEVICE_ID_W-1:0]),
      .ADDR (bus_ctrl_pkg::SR_DEVICE_ID)
   ) set_dev_id (
      .clk(clk), .i_arst_n(i_arst_n),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .o_value(device_id), .o_changed()
   );

   // Reference clock frequency in Hz
   setting_reg #(
      .T         (bus_ctrl_pkg::set_data_t),
      .ADDR      (bus_ctrl_pkg::SR_REF_FREQ),
      .RESET_VAL (bus_ctrl_pkg::REF_FREQ_RESET)
   ) set_ref_freq (
      .clk(clk), .i_arst_n(i_arst_n),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .o_value(o_ref_freq), .o_changed(o_ref_freq_changed)
   );

   // SFP+ rate select, a set bit pulls the pin low
   setting_reg #(
      .T    (logic [bus_ctrl_pkg::SFPP_CTRL_W-1:0]),
      .ADDR (bus_ctrl_pkg::SR_SFPP_CTRL0)
   ) set_sfpp0_ctrl (
      .clk(clk), .i_arst_n(i_arst_n),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .o_value(o_sfpp0_rs), .o_changed()
   );

   setting_reg #(
      .T    (logic [bus_ctrl_pkg::SFPP_CTRL_W-1:0]),
      .ADDR (bus_ctrl_pkg::SR_SFPP_CTRL1)
   ) set_sfpp1_ctrl (
      .clk(clk), .i_arst_n(i_arst_n),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .o_value(o_sfpp1_rs), .o_changed()
   );

   // Front-panel GPIO source, two bits per pin
   setting_reg #(
      .T    (logic [bus_ctrl_pkg::GPIO_SRC_W-1:0]),
      .ADDR (bus_ctrl_pkg::SR_FP_GPIO_SRC)
   ) set_fp_gpio_src (
      .clk(clk), .i_arst_n(i_arst_n),
      .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
      .o_value(o_fp_gpio_src), .o_changed()
   );

   // --------------------------------------------------
   // SFP+ pin and PHY status
   // --------------------------------------------------
   sfp_status_monitor sfp0_mon (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_mod_abs    (i_sfpp0_mod_abs),
      .i_tx_fault   (i_sfpp0_tx_fault),
      .i_rx_los     (i_sfpp0_rx_los),
      .i_phy_status (i_sfp0_phy_status),
      .i_clear      (sfp0_clear),
      .o_status     (sfp0_status)
   );

   sfp_status_monitor sfp1_mon (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_mod_abs    (i_sfpp1_mod_abs),
      .i_tx_fault   (i_sfpp1_tx_fault),
      .i_rx_los     (i_sfpp1_rx_los),
      .i_phy_status (i_sfp1_phy_status),
      .i_clear      (sfp1_clear),
      .o_status     (sfp1_status)
   );

   // --------------------------------------------------
   // Readback
   // --------------------------------------------------
   readback_mux rb_mux (
      .clk            (clk),
      .i_arst_n       (i_arst_n),
      .i_rb_rd_stb    (i_rb_rd_stb),
      .i_rb_addr      (i_rb_addr),
      .i_device_id    (device_id),
      .i_clock_status (i_clock_status),
      .i_fp_gpio_src  (o_fp_gpio_src),
      .i_sfp0_status  (sfp0_status),
      .i_sfp1_status  (sfp1_status),
      .o_sfp0_clear   (sfp0_clear),
      .o_sfp1_clear   (sfp1_clear),
      .o_rb_data      (o_rb_data),
      .o_rb_valid     (o_rb_valid)
   );

endmodule

//--- src/readback_mux.sv
`timescale 1ns/1ps

module readback_mux (
   input  logic                                     clk,
   input  logic                                     i_arst_n,
   input  logic                                     i_rb_rd_stb,
   input  bus_ctrl_pkg::rb_addr_t                   i_rb_addr,
   input  logic [bus_ctrl_pkg::DEVICE_ID_W-1:0]     i_device_id,
   input  logic [7:0]                               i_clock_status,
   input  logic [bus_ctrl_pkg::GPIO_SRC_W-1:0]      i_fp_gpio_src,
   input  bus_ctrl_pkg::sfp_status_t                i_sfp0_status,
   input  bus_ctrl_pkg::sfp_status_t                i_sfp1_status,
   output logic                                     o_sfp0_clear,
   output logic                                     o_sfp1_clear,
   output bus_ctrl_pkg::rb_data_t                   o_rb_data,
   output logic                                     o_rb_valid
);

   bus_ctrl_pkg::rb_data_t counter;
   bus_ctrl_pkg::rb_data_t rb_sel;

   // --------------------------------------------------
   // Free-running cycle counter
   // --------------------------------------------------
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         counter <= '0;
      end else begin
         counter <= counter + 1'b1;
      end
   end

   // --------------------------------------------------
   // Address decode
   // --------------------------------------------------
   always_comb begin
      case (i_rb_addr)
         bus_ctrl_pkg::RB_COUNTER: begin
            rb_sel = counter;
         end
         bus_ctrl_pkg::RB_CLK_STATUS: begin
            rb_sel = bus_ctrl_pkg::rb_data_t'(i_clock_status);
         end
         bus_ctrl_pkg::RB_COMPAT_NUM: begin
            rb_sel = {bus_ctrl_pkg::COMPAT_MAJOR, bus_ctrl_pkg::COMPAT_MINOR};
         end
         bus_ctrl_pkg::RB_RFNOC_INFO: begin
            rb_sel = {i_device_id, bus_ctrl_pkg::PROTOVER};
         end
         bus_ctrl_pkg::RB_SFPP_STATUS0: begin
            rb_sel = i_sfp0_status;
         end
         bus_ctrl_pkg::RB_SFPP_STATUS1: begin
            rb_sel = i_sfp1_status;
         end
         bus_ctrl_pkg::RB_FP_GPIO_SRC: begin
            rb_sel = bus_ctrl_pkg::rb_data_t'(i_fp_gpio_src);
         end
         default: begin
            rb_sel = '0;
         end
      endcase
   end

   // Clear-on-read pulses, same edge that captures the word
   assign o_sfp0_clear = i_rb_rd_stb && (i_rb_addr == bus_ctrl_pkg::RB_SFPP_STATUS0);
   assign o_sfp1_clear = i_rb_rd_stb && (i_rb_addr == bus_ctrl_pkg::RB_SFPP_STATUS1);

   // --------------------------------------------------
   // Registered response
   // --------------------------------------------------
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_rb_valid <= 1'b0;
      end else begin
         o_rb_valid <= i_rb_rd_stb;
      end
   end

   // Data holds until the next read
   always_ff @(posedge clk) begin
      if (i_rb_rd_stb) begin
         o_rb_data <= rb_sel;
      end
   end

endmodule

//--- src/setting_reg.sv
`timescale 1ns/1ps

module setting_reg #(
   parameter type                     T         = logic,
   parameter bus_ctrl_pkg::set_addr_t ADDR      = '0,
   parameter T                        RESET_VAL = '0
) (
   input  logic                    clk,
   input  logic                    i_arst_n,
   input  logic                    i_set_stb,
   input  bus_ctrl_pkg::set_addr_t i_set_addr,
   input  bus_ctrl_pkg::set_data_t i_set_data,
   output T                        o_value,
   output logic                    o_changed
);

   localparam int W = $bits(T);

   logic wr_hit;

   // Strobe qualified by this register's address
   assign wr_hit = i_set_stb && (i_set_addr == ADDR);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_value   <= RESET_VAL;
         o_changed <= 1'b0;
      end else begin
         // Pulses on every matching write, same value or not
         o_changed <= wr_hit;
         if (wr_hit) begin
            o_value <= T'(i_set_data[W-1:0]);
         end
      end
   end

endmodule

//--- src/sfp_status_monitor.sv
`timescale 1ns/1ps

module sfp_status_monitor (
   input  logic                      clk,
   input  logic                      i_arst_n,
   input  logic                      i_mod_abs,
   input  logic                      i_tx_fault,
   input  logic                      i_rx_los,
   input  bus_ctrl_pkg::phy_status_t i_phy_status,
   input  logic                      i_clear,
   output bus_ctrl_pkg::sfp_status_t o_status
);

   // Pin vectors ordered {mod_abs, tx_fault, rx_los}
   logic [2:0]                pin_meta;
   logic [2:0]                pin_sync;
   logic [2:0]                pin_prev;
   logic [2:0]                pin_chgd;
   bus_ctrl_pkg::phy_status_t phy_meta;
   bus_ctrl_pkg::phy_status_t phy_sync;

   // --------------------------------------------------
   // Two-flop synchronizers
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      pin_meta <= {i_mod_abs, i_tx_fault, i_rx_los};
      pin_sync <= pin_meta;
      phy_meta <= i_phy_status;
      phy_sync <= phy_meta;
   end

   // Previous synchronized pin state for edge detection
   always_ff @(posedge clk) begin
      pin_prev <= pin_sync;
   end

   // --------------------------------------------------
   // Sticky change flags
   // --------------------------------------------------
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pin_chgd <= '0;
      end else if (i_clear) begin
         // Clear beats a change seen on the same edge
         pin_chgd <= '0;
      end else begin
         pin_chgd <= pin_chgd | (pin_sync ^ pin_prev);
      end
   end

   // Pack the readback word
   always_comb begin
      o_status               = '0;
      o_status.phy_status    = phy_sync;
      o_status.mod_abs_chgd  = pin_chgd[2];
      o_status.tx_fault_chgd = pin_chgd[1];
      o_status.rx_los_chgd   = pin_chgd[0];
      o_status.mod_abs       = pin_sync[2];
      o_status.tx_fault      = pin_sync[1];
      o_status.rx_los        = pin_sync[0];
   end

endmodule
